/* build.f */
+incdir+.
fp_pkg.sv
noncomp_pkg.sv
fp_classifier.sv
fp_sign_inject.sv
fp_order_unit.sv
noncomp_datapath.sv
noncomp_pipe_stage.sv
fp_noncomp.sv
tb_fp_noncomp.sv

/* tb_fp_noncomp.sv */
// Directed testbench for the non-computational binary32 FPU
// Reference model and tag-matched response checks
`timescale 1ns/1ps

module tb_fp_noncomp import fp_pkg::*, noncomp_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  // 16 + 18 + 42 + 10 + 41 + 2 requests over all tests
  localparam int TOTAL_REQS = 129;

  logic    clk_i = 1'b0;
  logic    rst_n_i;
  logic    flush_i;
  logic    in_valid_i;
  nc_req_t in_req_i;
  logic    in_ready_o;
  logic    out_valid_o;
  nc_rsp_t out_rsp_o;
  logic    out_ready_i;
  logic    busy_o;

  int      errors = 0;
  int      checks = 0;
  int      cyc = 0;
  integer  seed = 32'h879b;
  logic    bp_en = 1'b0;
  nc_req_t pend_q[$];
  nc_rsp_t rsp_q[$];
  int      rsp_cyc_q[$];

  fp_noncomp u_fp_noncomp (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_req_i    (in_req_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_rsp_o   (out_rsp_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // --------------------------------------------------
  // Clock, cycle count, response monitor
  // --------------------------------------------------
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // Mid-cycle sample of the output handshake
  // Logged cycle is the edge that completes it
  always @(negedge clk_i) begin
    if (out_valid_o && out_ready_i) begin
      rsp_q.push_back(out_rsp_o);
      rsp_cyc_q.push_back(cyc + 1);
    end
  end

  // Random downstream back-pressure
  always @(posedge clk_i) begin
    if (bp_en) begin
      #2;
      out_ready_i = $random(seed);
    end
  end

  // Watchdog scaled to the request count
  initial begin
    #((TOTAL_REQS * 40 + 1000) * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Bit position in the class mask
  function automatic int class_index(input fp32_t v);
    if (v.exponent == 8'hff) begin
      if (v.mantissa == 0) return v.sign ? 0 : 7;
      return v.mantissa[22] ? 9 : 8;
    end
    if (v.exponent == 8'h00) begin
      if (v.mantissa == 0) return v.sign ? 3 : 4;
      return v.sign ? 2 : 5;
    end
    return v.sign ? 1 : 6;
  endfunction

  function automatic nc_rsp_t model_rsp(input nc_req_t r);
    nc_rsp_t     rsp;
    fp32_t       a;
    fp32_t       b;
    logic        a_nan;
    logic        b_nan;
    logic        any_snan;
    logic [31:0] key_a;
    logic [31:0] key_b;
    logic        lt_key;
    logic        eq;
    logic        res_bit;
    a = r.operand_a;
    b = r.operand_b;
    rsp = '0;
    rsp.tag = r.tag;
    rsp.class_mask = fp_classmask_e'(10'b1 << class_index(a));
    a_nan = (a.exponent == 8'hff) && (a.mantissa != 0);
    b_nan = (b.exponent == 8'hff) && (b.mantissa != 0);
    any_snan = (a_nan && !a.mantissa[22]) || (b_nan && !b.mantissa[22]);
    // Monotonic key with negatives inverted, giving a total order
    key_a = a.sign ? ~a : (a | 32'h8000_0000);
    key_b = b.sign ? ~b : (b | 32'h8000_0000);
    lt_key = key_a < key_b;
    eq = (a == b) || ((a[30:0] == 0) && (b[30:0] == 0));
    res_bit = 1'b0;
    case (r.op)
      SGNJ: begin
        rsp.result = a;
        if (r.mode == MODE0) rsp.result.sign = b.sign;
        if (r.mode == MODE1) rsp.result.sign = ~b.sign;
        if (r.mode == MODE2) rsp.result.sign = a.sign ^ b.sign;
        rsp.extension_bit = r.op_mod ? rsp.result.sign : 1'b1;
      end
      MINMAX: begin
        rsp.extension_bit = 1'b1;
        rsp.status.NV = any_snan;
        if (a_nan && b_nan) rsp.result = 32'h7fc0_0000;
        else if (a_nan) rsp.result = b;
        else if (b_nan) rsp.result = a;
        else if (r.mode == MODE1) rsp.result = lt_key ? b : a;
        else rsp.result = lt_key ? a : b;
      end
      CMP: begin
        if (any_snan || ((a_nan || b_nan) && r.mode != MODE2)) rsp.status.NV = 1'b1;
        else if (r.mode == MODE0) res_bit = (lt_key || eq) ^ r.op_mod;
        else if (r.mode == MODE1) res_bit = (lt_key && !eq) ^ r.op_mod;
        else if (a_nan || b_nan) res_bit = r.op_mod;
        else res_bit = eq ^ r.op_mod;
        rsp.result = fp32_t'({31'b0, res_bit});
      end
      default: rsp.is_class = 1'b1;
    endcase
    return rsp;
  endfunction

  // --------------------------------------------------
  // Drive and check helpers
  // --------------------------------------------------
  function automatic nc_req_t make_req(input logic [31:0] a, input logic [31:0] b,
                                       input nc_op_e op, input nc_mode_e mode,
                                       input logic op_mod);
    nc_req_t r;
    r = '0;
    r.operand_a = a;
    r.operand_b = b;
    r.op = op;
    r.mode = mode;
    r.op_mod = op_mod;
    return r;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Entered 2 ns after an edge
  // Returns 2 ns after the accepting edge
  task automatic push_req(input nc_req_t req, output int acc_cyc);
    in_valid_i = 1'b1;
    in_req_i = req;
    #1;
    while (!in_ready_o) begin
      @(posedge clk_i);
      #3;
    end
    acc_cyc = cyc + 1;
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
  endtask

  task automatic wait_responses(input int n, input string name);
    int waited;
    waited = 0;
    while (rsp_q.size() < n && waited < n * 40 + 100) begin
      @(posedge clk_i);
      waited++;
    end
    // Idle cycles to catch stray extra responses
    repeat (3) @(posedge clk_i);
    #2;
    if (rsp_q.size() != n) begin
      errors++;
      $display("%s: got %0d responses for %0d requests", name, rsp_q.size(), n);
    end
  endtask

  // Pending requests go out in groups of 16 tags
  // Responses are matched by tag
  task automatic run_batch(input string name);
    nc_rsp_t exp_by_tag[16];
    bit      seen[16];
    nc_req_t req;
    int      n;
    int      acc;
    while (pend_q.size() > 0) begin
      n = (pend_q.size() > 16) ? 16 : pend_q.size();
      rsp_q.delete();
      rsp_cyc_q.delete();
      for (int i = 0; i < n; i++) begin
        req = pend_q.pop_front();
        req.tag = nc_tag_t'(i);
        exp_by_tag[i] = model_rsp(req);
        seen[i] = 1'b0;
        push_req(req, acc);
      end
      wait_responses(n, name);
      foreach (rsp_q[j]) begin
        if (rsp_q[j].tag >= n || seen[rsp_q[j].tag]) begin
          errors++;
          $display("%s: unexpected or repeated response, tag %0d", name, rsp_q[j].tag);
        end else begin
          seen[rsp_q[j].tag] = 1'b1;
          check_equal(name, exp_by_tag[rsp_q[j].tag], rsp_q[j]);
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic inject_signs();
    logic [31:0] a_ops[4] = '{32'h3fc0_0000, 32'h8000_0000, 32'h7fc0_0000, 32'hbf80_0000};
    logic [31:0] b_ops[4] = '{32'hc000_0000, 32'h4040_0000, 32'hc000_0000, 32'h0000_0000};
    // Mode in the low bits
    // op_mod alternates so each mode sees both values
    for (int i = 0; i < 16; i++) begin
      pend_q.push_back(make_req(a_ops[i / 4], b_ops[i / 4], SGNJ, nc_mode_e'(i % 4),
                                ((i % 4) ^ (i / 4)) & 1));
    end
    run_batch("sign_inject");
  endtask

  task automatic order_min_max();
    // Ordered, mixed zeros, quiet NaNs, signalling NaN
    logic [31:0] a_ops[9] = '{32'h3f80_0000, 32'hbf80_0000, 32'hc040_0000, 32'h0000_0000,
                              32'h8000_0000, 32'h7fc0_0000, 32'h3f80_0000, 32'h7fc0_0000,
                              32'h7f80_0001};
    logic [31:0] b_ops[9] = '{32'h4000_0000, 32'h4000_0000, 32'hc000_0000, 32'h8000_0000,
                              32'h0000_0000, 32'h3f80_0000, 32'h7fc0_0000, 32'hffc0_0000,
                              32'h3f80_0000};
    for (int i = 0; i < 18; i++) begin
      pend_q.push_back(make_req(a_ops[i / 2], b_ops[i / 2], MINMAX, nc_mode_e'(i % 2), 1'b0));
    end
    run_batch("min_max");
  endtask

  task automatic compare_pairs();
    logic [31:0] a_ops[7] = '{32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 32'h0000_0000,
                              32'hbf80_0000, 32'h7fc0_0000, 32'h3f80_0000};
    logic [31:0] b_ops[7] = '{32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h8000_0000,
                              32'hc000_0000, 32'h3f80_0000, 32'h7f80_0001};
    // LE, LT, EQ each with and without inversion
    for (int i = 0; i < 42; i++) begin
      pend_q.push_back(make_req(a_ops[i / 6], b_ops[i / 6], CMP, nc_mode_e'((i % 6) / 2),
                                i % 2));
    end
    run_batch("compare");
  endtask

  task automatic classify_values();
    logic [31:0] vals[10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                              32'h0000_0000, 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000,
                              32'h7f80_0001, 32'h7fc0_0000};
    for (int i = 0; i < 10; i++) begin
      pend_q.push_back(make_req(vals[i], 32'h0, CLASSIFY, MODE0, 1'b0));
    end
    run_batch("classify");
  endtask

  task automatic exercise_handshake();
    nc_req_t     req;
    nc_rsp_t     exp_q[$];
    logic [31:0] r;
    int          acc;
    // Lone request with fixed two-cycle latency
    rsp_q.delete();
    rsp_cyc_q.delete();
    req = make_req(32'h3f80_0000, 32'hc000_0000, SGNJ, MODE2, 1'b1);
    push_req(req, acc);
    wait_responses(1, "latency");
    if (rsp_q.size() == 1) begin
      check_equal("latency", model_rsp(req), rsp_q[0]);
      check_equal("latency", 2, rsp_cyc_q[0] - acc);
    end
    // Random requests under random back-pressure
    rsp_q.delete();
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      req = make_req($random(seed), $random(seed), nc_op_e'(r[1:0]), nc_mode_e'(r[3:2]), r[4]);
      if (req.op == MINMAX) req.mode = nc_mode_e'({1'b0, r[2]});
      if (req.op == CMP) req.mode = nc_mode_e'(r[3:2] % 3);
      req.tag = nc_tag_t'(i);
      exp_q.push_back(model_rsp(req));
      pend_q.push_back(req);
    end
    bp_en = 1'b1;
    while (pend_q.size() > 0) push_req(pend_q.pop_front(), acc);
    wait_responses(40, "backpressure");
    bp_en = 1'b0;
    @(posedge clk_i);
    #2;
    out_ready_i = 1'b1;
    foreach (rsp_q[i]) begin
      if (i < exp_q.size()) check_equal("backpressure", exp_q[i], rsp_q[i]);
    end
    check_equal("drain_busy", 1'b0, busy_o);
  endtask

  task automatic flush_in_flight();
    int acc;
    rsp_q.delete();
    out_ready_i = 1'b0;
    // Fill both stages
    push_req(make_req(32'h3f80_0000, 32'h4000_0000, CMP, MODE0, 1'b0), acc);
    push_req(make_req(32'h4000_0000, 32'h3f80_0000, MINMAX, MODE1, 1'b0), acc);
    check_equal("flush_full", 1'b1, busy_o);
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    #1;
    check_equal("flush_busy", 1'b0, busy_o);
    out_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #2;
    check_equal("flush_drop", 0, rsp_q.size());
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    in_req_i = '0;
    out_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    #1;
    // Idle state straight after reset
    check_equal("reset_ready", 1'b1, in_ready_o);
    check_equal("reset_valid", 1'b0, out_valid_o);
    check_equal("reset_busy", 1'b0, busy_o);
    @(posedge clk_i);
    #2;
    inject_signs();
    order_min_max();
    compare_pairs();
    classify_values();
    exercise_handshake();
    flush_in_flight();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* fp_noncomp.sv */
// Non-computational binary32 FPU, top level
// Input register slice, combinational datapath, output register slice
// Busy while either slice holds an item
`timescale 1ns/1ps

module fp_noncomp import noncomp_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  // Request handshake
  input  logic    in_valid_i,
  input  nc_req_t in_req_i,
  output logic    in_ready_o,
  // Response handshake
  output logic    out_valid_o,
  output nc_rsp_t out_rsp_o,
  input  logic    out_ready_i,
  // Items in flight
  output logic    busy_o
);

  logic    inp_valid;
  logic    inp_ready;
  nc_req_t inp_req;
  nc_rsp_t dp_rsp;

  // --------------------------------------------------
  // Input slice
  // --------------------------------------------------
  noncomp_pipe_stage #(
    .payload_t (nc_req_t)
  ) u_inp_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  (in_req_i),
    .ready_o (in_ready_o),
    .valid_o (inp_valid),
    .data_o  (inp_req),
    .ready_i (inp_ready)
  );

  // Zero-latency compute between the slices
  noncomp_datapath u_datapath (
    .req_i (inp_req),
    .rsp_o (dp_rsp)
  );

  // --------------------------------------------------
  // Output slice
  // --------------------------------------------------
  noncomp_pipe_stage #(
    .payload_t (nc_rsp_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (inp_valid),
    .data_i  (dp_rsp),
    .ready_o (inp_ready),
    .valid_o (out_valid_o),
    .data_o  (out_rsp_o),
    .ready_i (out_ready_i)
  );

  assign busy_o = inp_valid | out_valid_o;

endmodule

/* noncomp_pipe_stage.sv */
// One valid/ready register slice with synchronous flush
// Payload type is a parameter, used for both request and response
`timescale 1ns/1ps

module noncomp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  // Downstream side
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Can take a new item if ours leaves or the slot is empty
  assign ready_o = ready_i | ~valid_q;

  // Valid bit, flush drops whatever is held
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* noncomp_datapath.sv */
// Combinational datapath of the non-computational FPU
// Classifies both operands, builds the class mask and selects the response
`timescale 1ns/1ps

module noncomp_datapath import fp_pkg::*, noncomp_pkg::*; (
  input  nc_req_t req_i,
  output nc_rsp_t rsp_o
);

  fp_info_t      info_a;
  fp_info_t      info_b;
  fp32_t         sgnj_result;
  logic          sgnj_ext_bit;
  fp32_t         order_result;
  fp_status_t    order_status;
  fp_classmask_e class_mask;

  // --------------------------------------------------
  // Operand classification
  // --------------------------------------------------
  fp_classifier u_class_a (
    .operand_i (req_i.operand_a),
    .info_o    (info_a)
  );

  fp_classifier u_class_b (
    .operand_i (req_i.operand_b),
    .info_o    (info_b)
  );

  // --------------------------------------------------
  // Operation units
  // --------------------------------------------------
  fp_sign_inject u_sign_inject (
    .operand_a_i     (req_i.operand_a),
    .operand_b_i     (req_i.operand_b),
    .mode_i          (req_i.mode),
    .op_mod_i        (req_i.op_mod),
    .result_o        (sgnj_result),
    .extension_bit_o (sgnj_ext_bit)
  );

  fp_order_unit u_order_unit (
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .info_a_i    (info_a),
    .info_b_i    (info_b),
    .op_i        (req_i.op),
    .mode_i      (req_i.mode),
    .op_mod_i    (req_i.op_mod),
    .result_o    (order_result),
    .status_o    (order_status)
  );

  // Class mask of operand a only
  always_comb begin
    if (info_a.is_nan) begin
      class_mask = info_a.is_signalling ? SNAN : QNAN;
    end else if (info_a.is_inf) begin
      class_mask = req_i.operand_a.sign ? NEGINF : POSINF;
    end else if (info_a.is_zero) begin
      class_mask = req_i.operand_a.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_subnormal) begin
      class_mask = req_i.operand_a.sign ? NEGSUBNORM : POSSUBNORM;
    end else begin
      class_mask = req_i.operand_a.sign ? NEGNORM : POSNORM;
    end
  end

  // --------------------------------------------------
  // Response select
  // --------------------------------------------------
  always_comb begin
    // Fields common to all ops
    rsp_o            = '0;
    rsp_o.class_mask = class_mask;
    rsp_o.tag        = req_i.tag;
    case (req_i.op)
      SGNJ: begin
        rsp_o.result        = sgnj_result;
        rsp_o.extension_bit = sgnj_ext_bit;
      end
      MINMAX: begin
        rsp_o.result        = order_result;
        rsp_o.status        = order_status;
        // Float result, NaN-box style upper bits
        rsp_o.extension_bit = 1'b1;
      end
      CMP: begin
        rsp_o.result = order_result;
        rsp_o.status = order_status;
      end
      default: begin
        // CLASSIFY, answer is on class_mask
        rsp_o.is_class = 1'b1;
      end
    endcase
  end

endmodule

/* fp_order_unit.sv */
// Ordering unit for binary32
// Minimum/maximum with IEEE NaN rules and LE/LT/EQ compares with flags
`timescale 1ns/1ps
`include "noncomp_defines.svh"

module fp_order_unit import fp_pkg::*, noncomp_pkg::*; (
  input  fp32_t      operand_a_i,
  input  fp32_t      operand_b_i,
  input  fp_info_t   info_a_i,
  input  fp_info_t   info_b_i,
  input  nc_op_e     op_i,
  input  nc_mode_e   mode_i,
  input  logic       op_mod_i,
  output fp32_t      result_o,
  output fp_status_t status_o
);

  logic [`FP_WIDTH-1:0] bits_a;
  logic [`FP_WIDTH-1:0] bits_b;
  logic                 any_nan;
  logic                 any_snan;
  logic                 operands_equal;
  logic                 a_smaller;
  fp32_t                minmax_result;
  fp_status_t           minmax_status;
  logic                 cmp_bit;
  fp32_t                cmp_result;
  fp_status_t           cmp_status;

  // --------------------------------------------------
  // Ordering
  // --------------------------------------------------
  // Raw encodings, compared as unsigned integers
  assign bits_a = operand_a_i;
  assign bits_b = operand_b_i;

  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // +0 and -0 compare equal
  assign operands_equal = (bits_a == bits_b) | (info_a_i.is_zero & info_b_i.is_zero);
  // Sign-magnitude order flips once a negative value is involved
  assign a_smaller = (bits_a < bits_b) ^ (operand_a_i.sign | operand_b_i.sign);

  // --------------------------------------------------
  // Minimum / maximum
  // --------------------------------------------------
  always_comb begin
    minmax_status    = '0;
    // Quiet op, only sNaN is invalid
    minmax_status.NV = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result = FP_CANON_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_result = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result = operand_a_i;
    end else if (mode_i == MODE1) begin
      // MAX
      minmax_result = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      // MIN
      minmax_result = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // --------------------------------------------------
  // Comparisons
  // --------------------------------------------------
  always_comb begin
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (any_snan) begin
      // Always false and invalid
      cmp_status.NV = 1'b1;
    end else begin
      case (mode_i)
        // LE, signalling compare
        MODE0: begin
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller | operands_equal) ^ op_mod_i;
        end
        // LT, signalling compare
        MODE1: begin
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        // EQ, quiet compare, NaN is never equal
        MODE2: cmp_bit = any_nan ? op_mod_i : (operands_equal ^ op_mod_i);
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // Boolean lands in bit 0
  assign cmp_result = fp32_t'({{(`FP_WIDTH-1){1'b0}}, cmp_bit});

  // Output select
  assign result_o = (op_i == CMP) ? cmp_result : minmax_result;
  assign status_o = (op_i == CMP) ? cmp_status : minmax_status;

endmodule

/* fp_sign_inject.sv */
// Sign injection for binary32
// SGNJ, SGNJN, SGNJX or passthrough of operand a, plus integer extension bit
`timescale 1ns/1ps

module fp_sign_inject import fp_pkg::*, noncomp_pkg::*; (
  input  fp32_t    operand_a_i,
  input  fp32_t    operand_b_i,
  input  nc_mode_e mode_i,
  input  logic     op_mod_i,
  output fp32_t    result_o,
  output logic     extension_bit_o
);

  // Magnitude always comes from operand a
  always_comb begin
    result_o = operand_a_i;
    case (mode_i)
      // Copy sign of b
      MODE0: result_o.sign = operand_b_i.sign;
      // Negated sign of b
      MODE1: result_o.sign = ~operand_b_i.sign;
      // Product of both signs
      MODE2: result_o.sign = operand_a_i.sign ^ operand_b_i.sign;
      // Passthrough, a unchanged
      default: result_o = operand_a_i;
    endcase
  end

  // Sign extension when moved into an integer register
  // Otherwise upper bits are all ones
  assign extension_bit_o = op_mod_i ? result_o.sign : 1'b1;

endmodule

/* fp_classifier.sv */
// binary32 operand classifier
// Decodes exponent and mantissa into the six class flags
`timescale 1ns/1ps

module fp_classifier import fp_pkg::*; (
  input  fp32_t    operand_i,
  output fp_info_t info_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Field decodes
  assign exp_zero = (operand_i.exponent == '0);
  assign exp_ones = (operand_i.exponent == '1);
  assign man_zero = (operand_i.mantissa == '0);

  // Finite values
  assign info_o.is_normal    = ~exp_zero & ~exp_ones;
  assign info_o.is_subnormal = exp_zero & ~man_zero;
  assign info_o.is_zero      = exp_zero & man_zero;

  // Specials with all-ones exponent
  assign info_o.is_inf = exp_ones & man_zero;
  assign info_o.is_nan = exp_ones & ~man_zero;

  // Quiet bit is the mantissa MSB, clear means signalling
  assign info_o.is_signalling = exp_ones & ~man_zero & ~operand_i.mantissa[$high(operand_i.mantissa)];

endmodule

/* noncomp_pkg.sv */
// Unit-level types of the non-computational FPU
// Operation select, sub-operation mode, request and response records
`include "noncomp_defines.svh"

package noncomp_pkg;
  import fp_pkg::*;

  // --------------------------------------------------
  // Operation select
  // --------------------------------------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } nc_op_e;

  // Sub-operation, meaning depends on op
  // MODE0  SGNJ / MIN / LE
  // MODE1  SGNJN / MAX / LT
  // MODE2  SGNJX / EQ
  // MODE3  passthrough for sign injection
  typedef enum logic [1:0] {
    MODE0 = 2'd0,
    MODE1 = 2'd1,
    MODE2 = 2'd2,
    MODE3 = 2'd3
  } nc_mode_e;

  typedef logic [`NC_TAG_WIDTH-1:0] nc_tag_t;

  // --------------------------------------------------
  // Request and response
  // --------------------------------------------------
  typedef struct packed {
    fp32_t    operand_a;
    fp32_t    operand_b;
    nc_op_e   op;
    nc_mode_e mode;
    logic     op_mod;  // inverts compares, enables sign extension for SGNJ
    nc_tag_t  tag;
  } nc_req_t;

  typedef struct packed {
    fp32_t         result;
    fp_status_t    status;
    logic          extension_bit;
    fp_classmask_e class_mask;
    logic          is_class;
    nc_tag_t       tag;
  } nc_rsp_t;

endpackage

/* fp_pkg.sv */
// binary32 format types
// Value layout, per-operand class info, classify mask and status flags
`include "noncomp_defines.svh"

package fp_pkg;

  // --------------------------------------------------
  // Field types
  // --------------------------------------------------
  typedef logic [`FP_EXP_BITS-1:0] fp_exp_t;
  typedef logic [`FP_MAN_BITS-1:0] fp_man_t;

  // Sign in the MSB, mantissa in the LSBs
  typedef struct packed {
    logic    sign;
    fp_exp_t exponent;
    fp_man_t mantissa;
  } fp32_t;

  // Class flags of one operand, exactly one of the first five is set
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE exception flags
  typedef struct packed {
    logic NV;  // invalid operation
    logic DZ;  // divide by zero
    logic OF;  // overflow
    logic UF;  // underflow
    logic NX;  // inexact
  } fp_status_t;

  // One-hot classify result, same bit order as the RISC-V FCLASS result
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } fp_classmask_e;

  // Canonical quiet NaN, positive with only the quiet bit set
  localparam fp32_t FP_CANON_QNAN = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(`FP_MAN_BITS-1){1'b0}}}
  };

endpackage

/* noncomp_defines.svh */
// Global widths for the non-computational FPU
// binary32 field sizes and request tag size
`ifndef NONCOMP_DEFINES_SVH
`define NONCOMP_DEFINES_SVH

// --------------------------------------------------
// binary32 layout
// --------------------------------------------------
// Biased exponent field
`define FP_EXP_BITS 8
// Stored mantissa, hidden bit not included
`define FP_MAN_BITS 23
// Sign, exponent and mantissa together
`define FP_WIDTH 32

// --------------------------------------------------
// Unit level
// --------------------------------------------------
// Tag carried alongside every request
`define NC_TAG_WIDTH 4

`endif
